//--- dsd_dac_macros.svh
// tap depth, element pair count, permutation count and index width for the dsd dac
`ifndef DSD_DAC_MACROS_SVH
`define DSD_DAC_MACROS_SVH

// history depth in taps
// also the number of dac elements per set
`define DSD_TAPS 8

// element pairs per set
// each pair is two adjacent elements
`define DEM_PAIRS 4

// rows in the element permutation table
`define DEM_PATTERNS 32

// permutation counter width
// must cover DEM_PATTERNS
`define DEM_IDX_W 5

`endif

//--- dsd_dac_pkg.sv
// dsd dac vector types, differential pair struct and dem permutation table
`include "dsd_dac_macros.svh"

package dsd_dac_pkg;

  // one bit per dac element or history tap
  typedef logic [`DSD_TAPS-1:0] dsd_word_t;

  // permutation counter value
  typedef logic [`DEM_IDX_W-1:0] dem_index_t;

  // source pair feeding one output pair
  typedef logic [1:0] pair_sel_t;

  // selects for all output pairs, entry r drives output pair r
  typedef pair_sel_t [`DEM_PAIRS-1:0] dem_sel_t;

  // differential element lines of one channel
  typedef struct packed {
    dsd_word_t pos;
    dsd_word_t neg;
  } dsd_diff_t;

  // element permutations, one row per counter value
  // fields written p3 down to p0
  // rows 0..23 cover all 24 orders, rows 24..31 repeat some of them
  localparam dem_sel_t dem_perm_table [`DEM_PATTERNS] = '{
    {2'd3, 2'd2, 2'd1, 2'd0},
    {2'd2, 2'd3, 2'd1, 2'd0},
    {2'd3, 2'd1, 2'd2, 2'd0},
    {2'd1, 2'd3, 2'd2, 2'd0},
    {2'd2, 2'd1, 2'd3, 2'd0},
    {2'd1, 2'd2, 2'd3, 2'd0},
    {2'd3, 2'd2, 2'd0, 2'd1},
    {2'd2, 2'd3, 2'd0, 2'd1},
    {2'd0, 2'd3, 2'd2, 2'd1},
    {2'd3, 2'd0, 2'd2, 2'd1},
    {2'd2, 2'd0, 2'd3, 2'd1},
    {2'd0, 2'd2, 2'd3, 2'd1},
    {2'd1, 2'd0, 2'd3, 2'd2},
    {2'd0, 2'd1, 2'd3, 2'd2},
    {2'd0, 2'd3, 2'd1, 2'd2},
    {2'd3, 2'd0, 2'd1, 2'd2},
    {2'd3, 2'd1, 2'd0, 2'd2},
    {2'd1, 2'd3, 2'd0, 2'd2},
    {2'd1, 2'd2, 2'd0, 2'd3},
    {2'd2, 2'd1, 2'd0, 2'd3},
    {2'd2, 2'd0, 2'd1, 2'd3},
    {2'd0, 2'd2, 2'd1, 2'd3},
    {2'd1, 2'd0, 2'd2, 2'd3},
    {2'd0, 2'd1, 2'd2, 2'd3},
    // extra rows
    {2'd0, 2'd1, 2'd2, 2'd3},
    {2'd0, 2'd3, 2'd1, 2'd2},
    {2'd1, 2'd3, 2'd2, 2'd0},
    {2'd3, 2'd2, 2'd0, 2'd1},
    {2'd0, 2'd2, 2'd3, 2'd1},
    {2'd3, 2'd2, 2'd1, 2'd0},
    {2'd2, 2'd1, 2'd0, 2'd3},
    {2'd0, 2'd1, 2'd3, 2'd2}
  };

endpackage

//--- dsd_shift_channel.sv
// single channel dsd history shift register with stability and capture checks
`include "dsd_dac_macros.svh"

module dsd_shift_channel
  import dsd_dac_pkg::*;
(
  input  logic      mclk,
  input  logic      reset_n,
  input  logic      dsd_strobe_i,
  input  logic      dsd_bit_i,
  output dsd_word_t history_o
);

  // last DSD_TAPS bits, newest in bit 0
  dsd_word_t history_q;

  // shift only on a bit strobe
  // older bits move one tap up, oldest falls off the top
  always_ff @(posedge mclk or negedge reset_n) begin
    if (!reset_n) begin
      history_q <= '0;
    end else if (dsd_strobe_i) begin
      history_q <= {history_q[`DSD_TAPS-2:0], dsd_bit_i};
    end
  end

  assign history_o = history_q;

  // no strobe, no movement
  a_hold_no_strobe: assert property (
    @(posedge mclk) disable iff (!reset_n)
    !dsd_strobe_i |=> $stable(history_o)
  );

  // strobed bit lands in tap 0 on the next cycle
  // and the rest of the word moved up by one
  a_capture_bit: assert property (
    @(posedge mclk) disable iff (!reset_n)
    dsd_strobe_i |=> (history_o[0] == $past(dsd_bit_i)) &&
                     (history_o[`DSD_TAPS-1:1] == $past(history_o[`DSD_TAPS-2:0]))
  );

endmodule

//--- dem_permuter.sv
// dem permutation counter and table lookup producing output pair selects
`include "dsd_dac_macros.svh"

module dem_permuter
  import dsd_dac_pkg::*;
(
  input  logic     mclk,
  input  logic     reset_n,
  input  logic     dsd_strobe_i,
  output dem_sel_t dem_sel_o
);

  // current permutation row
  dem_index_t idx_q;

  // one step per dsd bit
  // runs whether scrambling is on or not
  // wraps naturally at DEM_PATTERNS
  always_ff @(posedge mclk or negedge reset_n) begin
    if (!reset_n) begin
      idx_q <= '0;
    end else if (dsd_strobe_i) begin
      idx_q <= idx_q + dem_index_t'(1);
    end
  end

  // plain lookup, no register
  // select changes right after the strobe edge
  assign dem_sel_o = dem_perm_table[idx_q];

  // exactly one step per strobe, modulo the table size
  a_idx_step: assert property (
    @(posedge mclk) disable iff (!reset_n)
    dsd_strobe_i |=> idx_q == dem_index_t'($past(idx_q) + dem_index_t'(1))
  );

endmodule

//--- dsd_dac_driver.sv
// differential element driver with optional dem scrambling, output registers and pair checks
`include "dsd_dac_macros.svh"

module dsd_dac_driver
  import dsd_dac_pkg::*;
(
  input  logic      mclk,
  input  logic      reset_n,
  input  logic      dsd_strobe_i,
  input  logic      dem_en_i,
  input  dsd_word_t hist_l_i,
  input  dsd_word_t hist_r_i,
  output dsd_diff_t dac_l_o,
  output dsd_diff_t dac_r_o
);

  // shared select for both channels
  dem_sel_t  dem_sel;

  dsd_diff_t dac_l_d;
  dsd_diff_t dac_r_d;
  dsd_diff_t dac_l_q;
  dsd_diff_t dac_r_q;

  // source pair p sits at word bits 7-2p and 6-2p
  function automatic logic [1:0] pair_src(dsd_word_t w, pair_sel_t p);
    return w[`DSD_TAPS-1-2*int'(p) -: 2];
  endfunction

  // pos and neg sets for one channel
  function automatic dsd_diff_t drive_word(dsd_word_t w, dem_sel_t sel, logic en);
    dsd_diff_t d;
    d.pos = w;
    // scrambled: output pair r fed by source pair sel[r]
    if (en) begin
      for (int r = 0; r < `DEM_PAIRS; r++) begin
        d.pos[2*r]   = w[`DSD_TAPS-1-2*int'(sel[r])];
        d.pos[2*r+1] = w[`DSD_TAPS-2-2*int'(sel[r])];
      end
    end
    // neg runs the other way round, inverted
    for (int k = 0; k < `DSD_TAPS; k++) begin
      d.neg[k] = ~w[`DSD_TAPS-1-k];
    end
    return d;
  endfunction

  dem_permuter u_permuter (
    .mclk         (mclk),
    .reset_n      (reset_n),
    .dsd_strobe_i (dsd_strobe_i),
    .dem_sel_o    (dem_sel)
  );

  // next element states
  always_comb begin
    dac_l_d = drive_word(hist_l_i, dem_sel, dem_en_i);
    dac_r_d = drive_word(hist_r_i, dem_sel, dem_en_i);
  end

  // element lines retimed every mclk
  always_ff @(posedge mclk or negedge reset_n) begin
    if (!reset_n) begin
      dac_l_q <= '0;
      dac_r_q <= '0;
    end else begin
      dac_l_q <= dac_l_d;
      dac_r_q <= dac_r_d;
    end
  end

  assign dac_l_o = dac_l_q;
  assign dac_r_o = dac_r_q;

  // scrambling moves bits between pairs, never drops or adds one
  // checked against the history and select seen a cycle earlier
  for (genvar r = 0; r < `DEM_PAIRS; r++) begin : g_pair_chk
    a_pair_ones: assert property (
      @(posedge mclk) disable iff (!reset_n)
      $past(dem_en_i) |->
        ($countones(dac_l_o.pos[2*r +: 2]) ==
         $past($countones(pair_src(hist_l_i, dem_sel[r])))) &&
        ($countones(dac_r_o.pos[2*r +: 2]) ==
         $past($countones(pair_src(hist_r_i, dem_sel[r]))))
    );
  end

endmodule

//--- dsd_dac_top.sv
// one bit dsd dac top level with left and right history shifters and the element driver
module dsd_dac_top
  import dsd_dac_pkg::*;
(
  input  logic      mclk,
  input  logic      reset_n,
  input  logic      dsd_strobe_i,
  input  logic      dsd_l_i,
  input  logic      dsd_r_i,
  input  logic      dem_en_i,
  output dsd_diff_t dac_l_o,
  output dsd_diff_t dac_r_o
);

  // per channel history words
  dsd_word_t hist_l;
  dsd_word_t hist_r;

  // left channel history
  dsd_shift_channel u_left (
    .mclk         (mclk),
    .reset_n      (reset_n),
    .dsd_strobe_i (dsd_strobe_i),
    .dsd_bit_i    (dsd_l_i),
    .history_o    (hist_l)
  );

  // right channel history, same strobe
  dsd_shift_channel u_right (
    .mclk         (mclk),
    .reset_n      (reset_n),
    .dsd_strobe_i (dsd_strobe_i),
    .dsd_bit_i    (dsd_r_i),
    .history_o    (hist_r)
  );

  // shared dem select, registered element outputs
  dsd_dac_driver u_driver (
    .mclk         (mclk),
    .reset_n      (reset_n),
    .dsd_strobe_i (dsd_strobe_i),
    .dem_en_i     (dem_en_i),
    .hist_l_i     (hist_l),
    .hist_r_i     (hist_r),
    .dac_l_o      (dac_l_o),
    .dac_r_o      (dac_r_o)
  );

endmodule

//--- tb_dsd_dac_top.sv
// dsd_dac_top testbench with clock, reset, watchdog, reference model, compare task and directed tests
`include "dsd_dac_macros.svh"

module tb_dsd_dac_top
  import dsd_dac_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // clock and reset timing
  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 4;

  // test lengths in strobes or cycles
  localparam int PASS_STROBES     = 20;
  localparam int SCRAMBLE_STROBES = 40;
  localparam int INDEP_STROBES    = `DSD_TAPS;
  localparam int HOLD_CYCLES      = 10;

  // each strobe takes one drive cycle, one capture cycle and one output cycle
  localparam int CYCLES_PER_STROBE = 3;
  localparam int TOTAL_STROBES = PASS_STROBES + SCRAMBLE_STROBES + 2 * INDEP_STROBES;
  localparam int TOTAL_CYCLES  = RESET_CYCLES + 2 + HOLD_CYCLES +
                                 TOTAL_STROBES * CYCLES_PER_STROBE;
  // generous slack on top of the expected run length
  localparam int WATCHDOG_NS   = (TOTAL_CYCLES + 50) * CLK_PERIOD;

  // dut inputs
  logic mclk;
  logic reset_n;
  logic dsd_strobe_i;
  logic dsd_l_i;
  logic dsd_r_i;
  logic dem_en_i;

  // dut outputs
  dsd_diff_t dac_l_o;
  dsd_diff_t dac_r_o;

  // reference model state
  dsd_word_t model_l;
  dsd_word_t model_r;
  int        strobe_count;

  // random stream
  integer seed;

  dsd_dac_top dut_i (
    .mclk         (mclk),
    .reset_n      (reset_n),
    .dsd_strobe_i (dsd_strobe_i),
    .dsd_l_i      (dsd_l_i),
    .dsd_r_i      (dsd_r_i),
    .dem_en_i     (dem_en_i),
    .dac_l_o      (dac_l_o),
    .dac_r_o      (dac_r_o)
  );

  // free running master clock
  initial begin
    mclk = 1'b0;
    forever #(CLK_PERIOD / 2) mclk = ~mclk;
  end

  // run length guard
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired: the tests did not finish in %0d ns", WATCHDOG_NS);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped by watchdog");
  end

  // expected pos set
  // output pair r takes source pair p = table select, p counted from the top of the word
  function automatic dsd_word_t expect_pos(dsd_word_t w, int count, logic en);
    dem_sel_t  sel;
    dsd_word_t p;
    int        src;
    sel = dem_perm_table[count % `DEM_PATTERNS];
    p = w;
    if (en) begin
      for (int r = 0; r < `DEM_PAIRS; r++) begin
        src = int'(sel[r]);
        p[2*r]   = w[7 - 2*src];
        p[2*r+1] = w[6 - 2*src];
      end
    end
    return p;
  endfunction

  // expected neg set, reversed and inverted, dem has no effect
  function automatic dsd_word_t expect_neg(dsd_word_t w);
    dsd_word_t n;
    for (int k = 0; k < `DSD_TAPS; k++) begin
      n[k] = ~w[`DSD_TAPS - 1 - k];
    end
    return n;
  endfunction

  // single compare, stops at the first mismatch
  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("[ERROR] %0d ns: %s mismatch, got 0x%0h expected 0x%0h",
               $time, what, actual, expected);
      $display("STATUS: FAIL");
      $fatal(1, "output check failed");
    end
  endtask

  // all four element sets against the model
  task automatic check_outputs(input string label, input logic en);
    check_equal(dac_l_o.pos, expect_pos(model_l, strobe_count, en), {label, " left pos"});
    check_equal(dac_l_o.neg, expect_neg(model_l), {label, " left neg"});
    check_equal(dac_r_o.pos, expect_pos(model_r, strobe_count, en), {label, " right pos"});
    check_equal(dac_r_o.neg, expect_neg(model_r), {label, " right neg"});
  endtask

  // one dsd bit per channel, checked two cycles after capture
  task automatic apply_strobe(input logic bit_l, input logic bit_r, input logic en,
                              input string label);
    @(posedge mclk);
    dsd_strobe_i <= 1'b1;
    dsd_l_i      <= bit_l;
    dsd_r_i      <= bit_r;
    dem_en_i     <= en;
    // capture edge
    @(posedge mclk);
    dsd_strobe_i <= 1'b0;
    // inverted data while idle, must not be taken
    dsd_l_i      <= ~bit_l;
    dsd_r_i      <= ~bit_r;
    model_l = {model_l[`DSD_TAPS-2:0], bit_l};
    model_r = {model_r[`DSD_TAPS-2:0], bit_r};
    strobe_count++;
    // output register edge, then sample mid cycle
    @(posedge mclk);
    @(negedge mclk);
    check_outputs(label, en);
  endtask

  // outputs stay zero through reset and right after release
  task automatic test_reset();
    repeat (RESET_CYCLES - 1) @(posedge mclk);
    @(negedge mclk);
    check_equal(dac_l_o, '0, "reset left struct");
    check_equal(dac_r_o, '0, "reset right struct");
    @(posedge mclk);
    reset_n <= 1'b1;
    @(negedge mclk);
    check_equal(dac_l_o, '0, "post reset left struct");
    check_equal(dac_r_o, '0, "post reset right struct");
  endtask

  // dem off, pos is the plain history
  task automatic test_pass_through();
    logic bl;
    logic br;
    for (int i = 0; i < PASS_STROBES; i++) begin
      bl = $random(seed);
      br = $random(seed);
      apply_strobe(bl, br, 1'b0, "pass-through");
    end
  endtask

  // no strobes, outputs frozen even with data toggling
  task automatic test_hold();
    dsd_diff_t snap_l;
    dsd_diff_t snap_r;
    snap_l = dac_l_o;
    snap_r = dac_r_o;
    for (int i = 0; i < HOLD_CYCLES; i++) begin
      @(posedge mclk);
      dsd_l_i <= $random(seed);
      dsd_r_i <= $random(seed);
      @(negedge mclk);
      check_equal(dac_l_o, snap_l, "hold left struct");
      check_equal(dac_r_o, snap_r, "hold right struct");
      check_outputs("hold", dem_en_i);
    end
  endtask

  // dem on, index wraps past the table end
  task automatic test_scrambling();
    logic bl;
    logic br;
    for (int i = 0; i < SCRAMBLE_STROBES; i++) begin
      bl = $random(seed);
      br = $random(seed);
      apply_strobe(bl, br, 1'b1, "scrambling");
    end
  endtask

  // left fed ones, right fed zeros, one run per dem mode
  task automatic run_independence(input logic en, input string label);
    for (int i = 0; i < INDEP_STROBES; i++) begin
      apply_strobe(1'b1, 1'b0, en, label);
    end
    // fully flushed, fixed levels whatever the permutation
    check_equal(dac_l_o.pos, 32'hff, {label, " left pos ones"});
    check_equal(dac_l_o.neg, 32'h00, {label, " left neg zeros"});
    check_equal(dac_r_o.pos, 32'h00, {label, " right pos zeros"});
    check_equal(dac_r_o.neg, 32'hff, {label, " right neg ones"});
  endtask

  task automatic test_channel_independence();
    run_independence(1'b0, "independence dem off");
    run_independence(1'b1, "independence dem on");
  endtask

  // main sequence
  initial begin
    seed         = 95;
    model_l      = '0;
    model_r      = '0;
    strobe_count = 0;
    reset_n      = 1'b0;
    dsd_strobe_i = 1'b0;
    dsd_l_i      = 1'b0;
    dsd_r_i      = 1'b0;
    dem_en_i     = 1'b0;

    test_reset();
    test_pass_through();
    test_hold();
    test_scrambling();
    test_channel_independence();

    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- dsd_dac_top.f
+incdir+.
dsd_dac_pkg.sv
dsd_shift_channel.sv
dem_permuter.sv
dsd_dac_driver.sv
dsd_dac_top.sv
tb_dsd_dac_top.sv
